//--- src.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/wordMemory.sv
verilog/accessPort.sv
verilog/memoryArbiter.sv
verilog/registerFile.sv
verilog/controlUnit.sv
verilog/cpuCore.sv
tests/cpuCoreTb.sv

//--- tests/cpuCoreTb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuCoreTb;
	import cpuPkg::*;

	localparam int NumTests      = 6;
	localparam int CyclesPerTest = 400;
	localparam int CycleLimit    = NumTests * CyclesPerTest;

	logic        clk;
	logic        reset;
	logic        start;
	logic        hostRead;
	logic        hostWrite;
	addrT        hostAddr;
	dataT        hostWriteData;
	logic        busy;
	dataT        hostReadData;
	logic        hostAck;
	int          errorCount;
	int          checkCount;
	int          cycleCount;
	logic [15:0] lfsrState;
	dataT        shadow [`CPU_MEM_DEPTH];  // Expected memory contents
	addrT        progBase;                 // Where PC will be at the next start
	dataT        progWords [$];

	cpuCore cpuCore_inst (
		.clk(clk), .reset(reset), .start(start), .hostRead(hostRead),
		.hostWrite(hostWrite), .hostAddr(hostAddr), .hostWriteData(hostWriteData),
		.busy(busy), .hostReadData(hostReadData), .hostAck(hostAck)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// Taps 16, 14, 13, 11
	function automatic logic lfsrBit();
		logic feedback;
		feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], feedback};
		return feedback;
	endfunction

	function automatic dataT randomBits(input int count);
		dataT value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[6:0], lfsrBit()};
		return value;
	endfunction

	task automatic checkWord(input string name, input dataT expected, input dataT actual);
		checkCount++;
		assert (actual === expected)
		else begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s expected %02h, got %02h",
				$time, name, expected, actual);
		end
	endtask

	task automatic checkTrue(input logic condition, input string message);
		checkCount++;
		assert (condition)
		else begin
			errorCount++;
			$display("ERROR at %0t: %s", $time, message);
		end
	endtask

	task automatic idleCycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic hostWriteWord(input addrT address, input dataT data);
		hostWrite     = 1'b1;
		hostAddr      = address;
		hostWriteData = data;
		do begin
			@(posedge clk);
			#1;
		end while (!hostAck);
		hostWrite       = 1'b0;
		shadow[address] = data;
	endtask

	task automatic hostReadWord(input addrT address, output dataT data, output int latency);
		latency  = 0;
		hostRead = 1'b1;
		hostAddr = address;
		do begin
			@(posedge clk);
			#1;
			latency++;
		end while (!hostAck);
		data     = hostReadData;  // Valid with hostAck
		hostRead = 1'b0;
	endtask

	task automatic readAndCheck(input addrT address);
		dataT value;
		int   latency;
		hostReadWord(address, value, latency);
		checkWord($sformatf("hostReadData @%02h", address), shadow[address], value);
	endtask

	task automatic loadProgram();
		for (int i = 0; i < progWords.size(); i++)
			hostWriteWord(progBase + addrT'(i), progWords[i]);
	endtask

	task automatic startProgram();
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		checkTrue(busy, "busy did not rise after the start pulse");
	endtask

	task automatic waitForHalt();
		while (busy) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic buildArithmeticProgram(input addrT a);
		progWords = {dataT'(RSTAC), dataT'(LDADDR), a, dataT'(ADD), dataT'(INCAC),
			dataT'(STAC), dataT'(HALT)};
	endtask

	task automatic testHostRoundTrip();
		addrT written [$];
		addrT address;
		dataT value;
		int   latency;
		repeat (12) begin
			address = 8'h80 | randomBits(7);
			hostWriteWord(address, randomBits(8));
			written.push_back(address);
		end
		foreach (written[i]) begin
			idleCycles(1);  // Lets the arbiter return to idle
			hostReadWord(written[i], value, latency);
			checkWord($sformatf("hostReadData @%02h", written[i]), shadow[written[i]], value);
			checkTrue(latency == 1, "idle host read was not acknowledged one cycle after grant");
		end
	endtask

	task automatic testArithmeticStore();
		addrT a;
		a = 8'h80 | randomBits(7);
		buildArithmeticProgram(a);
		loadProgram();
		startProgram();
		waitForHalt();
		progBase  = progBase + addrT'(progWords.size());
		shadow[a] = a + 8'd1;
		readAndCheck(a);
	endtask

	task automatic testLoadIncrement();
		addrT p;
		dataT w;
		p = 8'h80 | randomBits(7);
		if (p == 8'hFF)
			p = 8'hFE;
		w = randomBits(8);
		hostWriteWord(p, w);
		hostWriteWord(p + 8'd1, ~(w + 8'd1));  // Differs from the result
		progWords = {dataT'(LDADDR), p, dataT'(LDAC), dataT'(INCAC), dataT'(INCADDR),
			dataT'(STAC), dataT'(HALT)};
		loadProgram();
		startProgram();
		waitForHalt();
		progBase           = progBase + addrT'(progWords.size());
		shadow[p + 8'd1]   = w + 8'd1;
		readAndCheck(p);
		readAndCheck(p + 8'd1);
	endtask

	// A skipped block moves ADDR, so the markers land elsewhere
	task automatic testJumps();
		addrT m;
		addrT b;
		m = 8'h80 | randomBits(7);
		if (m > 8'hFD)
			m = 8'hFD;
		b = progBase;
		hostWriteWord(m, 8'hEE);
		hostWriteWord(m + 8'd1, 8'hEE);
		hostWriteWord(m + 8'd2, 8'hEE);
		progWords = {dataT'(LDADDR), m, dataT'(RSTAC),
			dataT'(JMP), b + 8'd7, dataT'(INCADDR), dataT'(INCAC),
			dataT'(JMPZ), b + 8'd11, dataT'(INCADDR), dataT'(INCAC),
			dataT'(INCAC), dataT'(JMPZ), b + 8'd15, dataT'(STAC),
			dataT'(INCAC), dataT'(INCADDR), dataT'(STAC), dataT'(HALT)};
		loadProgram();
		startProgram();
		waitForHalt();
		progBase         = progBase + addrT'(progWords.size());
		shadow[m]        = 8'h01;
		shadow[m + 8'd1] = 8'h02;
		readAndCheck(m);
		readAndCheck(m + 8'd1);
		readAndCheck(m + 8'd2);
	endtask

	task automatic testContention();
		addrT a;
		addrT u;
		dataT value;
		int   latency;
		a = 8'h80 | randomBits(7);
		u = a ^ 8'h01;
		hostWriteWord(u, randomBits(8));
		buildArithmeticProgram(a);
		loadProgram();
		startProgram();
		while (busy) begin
			hostReadWord(u, value, latency);
			checkWord($sformatf("hostReadData @%02h", u), shadow[u], value);
			checkTrue(latency <= 3, "a contended host read waited more than two extra cycles");
			idleCycles(2 + randomBits(1));  // Gap gives the core a grant slot
		end
		progBase  = progBase + addrT'(progWords.size());
		shadow[a] = a + 8'd1;
		readAndCheck(a);
	endtask

	task automatic testHaltRestart();
		addrT m;
		m = 8'h80 | randomBits(7);
		if (m == 8'hFF)
			m = 8'hFE;
		hostWriteWord(m, 8'hEE);
		hostWriteWord(m + 8'd1, 8'hEE);
		progWords = {dataT'(LDADDR), m, dataT'(RSTAC), dataT'(INCAC), dataT'(STAC),
			dataT'(HALT), dataT'(INCAC), dataT'(STAC), dataT'(HALT)};
		loadProgram();
		startProgram();
		waitForHalt();
		shadow[m] = 8'h01;
		repeat (20) begin
			checkTrue(!busy, "busy rose after HALT without a start pulse");
			idleCycles(1);
		end
		readAndCheck(m);
		readAndCheck(m + 8'd1);
		startProgram();  // Resumes at the word after HALT
		waitForHalt();
		progBase  = progBase + addrT'(progWords.size());
		shadow[m] = 8'h02;
		readAndCheck(m);
		readAndCheck(m + 8'd1);
	endtask

	initial begin
		errorCount    = 0;
		checkCount    = 0;
		lfsrState     = 16'd82;
		progBase      = addrT'(`CPU_PC_RESET);
		reset         = 1'b1;
		start         = 1'b0;
		hostRead      = 1'b0;
		hostWrite     = 1'b0;
		hostAddr      = '0;
		hostWriteData = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		checkTrue(!busy && !hostAck, "busy or hostAck was high after reset");
		idleCycles(1);
		testHostRoundTrip();
		testArithmeticStore();
		testLoadIncrement();
		testJumps();
		testContention();
		testHaltRestart();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- verilog/accessPort.sv
`timescale 1ns/1ps

module accessPort #(
	parameter type payloadT = cpuPkg::dataT
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         req,
	input  cpuPkg::addrT address,
	input  logic         grantAck,
	input  cpuPkg::dataT readData,
	output logic         memReq,
	output cpuPkg::addrT memAddr,
	output logic         acq,
	output payloadT      payload
);

	logic    masked;
	payloadT heldPayload;

	assign memReq  = req && !masked;
	assign memAddr = address;
	assign acq     = grantAck;
	assign payload = grantAck ? payloadT'(readData) : heldPayload;  // Valid with acq

	// Blocks a second transaction while the level is still up
	always_ff @(posedge clk) begin
		if (reset)
			masked <= 1'b0;
		else if (grantAck)
			masked <= 1'b1;
		else if (!req)
			masked <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (grantAck)
			heldPayload <= payloadT'(readData);
	end

	assert property (@(posedge clk) disable iff (reset) grantAck |-> memReq);

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,
	input  cpuPkg::opcodeT      instruction,
	input  cpuPkg::dataT        memWord,
	input  logic                acZero,
	input  logic                fetchAck,
	input  logic                dataAck,
	output logic                busy,
	output logic                fetchReq,
	output logic                dataRead,
	output logic                dataWrite,
	output cpuPkg::dataAddrSelT dataAddrSel,
	output logic                acWrite,
	output cpuPkg::acSourceT    acSource,
	output logic                acInc,
	output logic                acReset,
	output logic                addrWrite,
	output logic                addrInc,
	output logic                pcWrite,
	output logic                pcInc
);
	import cpuPkg::*;

	stateT state;
	stateT nextState;

	assign busy = (state != ST_IDLE);

	always_ff @(posedge clk) begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= nextState;
	end

	always_comb begin
		nextState   = state;
		fetchReq    = 1'b0;
		dataRead    = 1'b0;
		dataWrite   = 1'b0;
		dataAddrSel = SEL_PC;
		acWrite     = 1'b0;
		acSource    = AC_FROM_MEM;
		acInc       = 1'b0;
		acReset     = 1'b0;
		addrWrite   = 1'b0;
		addrInc     = 1'b0;
		pcWrite     = 1'b0;
		pcInc       = 1'b0;
		case (state)
			ST_IDLE: begin
				if (start)
					nextState = ST_FETCH;
			end
			ST_FETCH: begin
				fetchReq = 1'b1;
				if (fetchAck) begin
					pcInc     = 1'b1;
					nextState = ST_DECODE;
				end
			end
			// Opcode is held by the fetch port here
			ST_DECODE: begin
				nextState = ST_FETCH;
				case (instruction)
					HALT:    nextState = ST_IDLE;
					RSTAC:   acReset = 1'b1;
					INCAC:   acInc = 1'b1;
					INCADDR: addrInc = 1'b1;
					ADD: begin
						acWrite  = 1'b1;
						acSource = AC_FROM_SUM;
					end
					LDADDR:  nextState = ST_LDADDR;
					LDAC:    nextState = ST_LDAC;
					STAC:    nextState = ST_STAC;
					JMP:     nextState = ST_JMP;
					JMPZ: begin
						if (acZero)
							nextState = ST_JMP;
						else
							pcInc = 1'b1;  // Skip the target word
					end
					default: nextState = ST_FETCH;
				endcase
			end
			ST_LDADDR: begin
				dataRead = 1'b1;
				if (dataAck) begin
					addrWrite = 1'b1;
					pcInc     = 1'b1;  // Past the operand
					nextState = ST_FETCH;
				end
			end
			ST_LDAC: begin
				dataRead    = 1'b1;
				dataAddrSel = SEL_ADDR;
				if (dataAck) begin
					acWrite   = 1'b1;
					nextState = ST_FETCH;
				end
			end
			ST_STAC: begin
				dataWrite   = 1'b1;
				dataAddrSel = SEL_ADDR;
				if (dataAck)
					nextState = ST_FETCH;
			end
			ST_JMP: begin
				dataRead = 1'b1;
				if (dataAck) begin
					pcWrite   = 1'b1;
					nextState = ST_FETCH;
				end
			end
			default: nextState = ST_IDLE;
		endcase
	end

	assert property (@(posedge clk) disable iff (reset) !(dataRead && dataWrite));

	// Operand words come from memory the host has loaded
	assert property (@(posedge clk) disable iff (reset)
		(dataRead && dataAck) |-> !$isunknown(memWord));

endmodule

//--- verilog/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  logic         hostRead,
	input  logic         hostWrite,
	input  cpuPkg::addrT hostAddr,
	input  cpuPkg::dataT hostWriteData,
	output logic         busy,
	output cpuPkg::dataT hostReadData,
	output logic         hostAck
);
	import cpuPkg::*;

	logic        fetchReq;
	logic        dataRead;
	logic        dataWrite;
	dataAddrSelT dataAddrSel;
	logic        acWrite;
	acSourceT    acSource;
	logic        acInc;
	logic        acReset;
	logic        addrWrite;
	logic        addrInc;
	logic        pcWrite;
	logic        pcInc;
	logic        acZero;
	logic        fetchAck;
	logic        dataAck;
	logic        fetchMemReq;
	logic        dataMemReq;
	logic        fetchGrantAck;
	logic        dataGrantAck;
	logic        memEnable;
	logic        memWrite;
	opcodeT      instruction;
	dataT        memWord;
	dataT        ac;
	dataT        ackData;
	dataT        memWriteData;
	dataT        memReadData;
	addrT        pc;
	addrT        addr;
	addrT        fetchAddr;
	addrT        dataAddr;
	addrT        memAddr;

	controlUnit controlUnit_inst (
		.clk(clk), .reset(reset), .start(start), .instruction(instruction),
		.memWord(memWord), .acZero(acZero), .fetchAck(fetchAck), .dataAck(dataAck),
		.busy(busy), .fetchReq(fetchReq), .dataRead(dataRead), .dataWrite(dataWrite),
		.dataAddrSel(dataAddrSel), .acWrite(acWrite), .acSource(acSource), .acInc(acInc),
		.acReset(acReset), .addrWrite(addrWrite), .addrInc(addrInc), .pcWrite(pcWrite),
		.pcInc(pcInc)
	);

	registerFile registerFile_inst (
		.clk(clk), .reset(reset), .acWrite(acWrite), .acSource(acSource), .acInc(acInc),
		.acReset(acReset), .addrWrite(addrWrite), .addrInc(addrInc), .pcWrite(pcWrite),
		.pcInc(pcInc), .memWord(memWord), .pc(pc), .addr(addr), .ac(ac), .acZero(acZero)
	);

	accessPort #(.payloadT(opcodeT)) fetchPort (
		.clk(clk), .reset(reset), .req(fetchReq), .address(pc), .grantAck(fetchGrantAck),
		.readData(ackData), .memReq(fetchMemReq), .memAddr(fetchAddr), .acq(fetchAck),
		.payload(instruction)
	);

	// Operand words come from PC, LDAC and STAC use ADDR
	accessPort #(.payloadT(dataT)) dataPort (
		.clk(clk), .reset(reset), .req(dataRead || dataWrite),
		.address(dataAddrSel == SEL_ADDR ? addr : pc), .grantAck(dataGrantAck),
		.readData(ackData), .memReq(dataMemReq), .memAddr(dataAddr), .acq(dataAck),
		.payload(memWord)
	);

	memoryArbiter memoryArbiter_inst (
		.clk(clk), .reset(reset), .hostReq(hostRead || hostWrite), .hostWrite(hostWrite),
		.hostAddr(hostAddr), .hostWriteData(hostWriteData), .dataReq(dataMemReq),
		.dataWrite(dataWrite), .dataAddr(dataAddr), .dataWriteData(ac),
		.fetchReq(fetchMemReq), .fetchAddr(fetchAddr), .memReadData(memReadData),
		.hostAck(hostAck), .hostReadData(hostReadData), .dataAck(dataGrantAck),
		.fetchAck(fetchGrantAck), .ackData(ackData), .memEnable(memEnable),
		.memWrite(memWrite), .memAddr(memAddr), .memWriteData(memWriteData)
	);

	wordMemory wordMemory_inst (
		.clk(clk), .enable(memEnable), .write(memWrite), .address(memAddr),
		.writeData(memWriteData), .readData(memReadData)
	);

endmodule

//--- verilog/cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

	typedef logic [`CPU_DATA_WIDTH-1:0] dataT;
	typedef logic [`CPU_ADDR_WIDTH-1:0] addrT;

	// Opcodes are one memory word
	typedef enum logic [7:0] {
		HALT    = 8'h00,
		RSTAC   = 8'h01,
		INCAC   = 8'h02,
		INCADDR = 8'h03,
		LDADDR  = 8'h04,
		LDAC    = 8'h05,
		STAC    = 8'h06,
		ADD     = 8'h07,
		JMP     = 8'h08,
		JMPZ    = 8'h09
	} opcodeT;

	typedef enum logic [7:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_LDADDR,
		ST_LDAC,
		ST_STAC,
		ST_JMP
	} stateT;

	typedef enum logic [1:0] {
		REQ_NONE,
		REQ_HOST,
		REQ_DATA,
		REQ_FETCH
	} requesterT;

	typedef enum logic {SEL_PC, SEL_ADDR} dataAddrSelT;
	typedef enum logic {AC_FROM_MEM, AC_FROM_SUM} acSourceT;

endpackage

//--- verilog/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Word and address widths
`define CPU_DATA_WIDTH 8
`define CPU_ADDR_WIDTH 8

// Full address space of words
`define CPU_MEM_DEPTH 256

`define CPU_PC_RESET 0  // Programs start at word zero

`endif

//--- verilog/memoryArbiter.sv
`timescale 1ns/1ps

module memoryArbiter (
	input  logic         clk,
	input  logic         reset,
	input  logic         hostReq,
	input  logic         hostWrite,
	input  cpuPkg::addrT hostAddr,
	input  cpuPkg::dataT hostWriteData,
	input  logic         dataReq,
	input  logic         dataWrite,
	input  cpuPkg::addrT dataAddr,
	input  cpuPkg::dataT dataWriteData,
	input  logic         fetchReq,
	input  cpuPkg::addrT fetchAddr,
	input  cpuPkg::dataT memReadData,
	output logic         hostAck,
	output cpuPkg::dataT hostReadData,
	output logic         dataAck,
	output logic         fetchAck,
	output cpuPkg::dataT ackData,
	output logic         memEnable,
	output logic         memWrite,
	output cpuPkg::addrT memAddr,
	output cpuPkg::dataT memWriteData
);
	import cpuPkg::*;

	requesterT owner;
	requesterT grant;

	// Fixed priority, only when idle
	always_comb begin
		grant = REQ_NONE;
		if (owner == REQ_NONE) begin
			if (hostReq)
				grant = REQ_HOST;
			else if (dataReq)
				grant = REQ_DATA;
			else if (fetchReq)
				grant = REQ_FETCH;
		end
	end

	always_comb begin
		memWrite     = 1'b0;
		memAddr      = fetchAddr;
		memWriteData = dataWriteData;
		case (grant)
			REQ_HOST: begin
				memWrite     = hostWrite;
				memAddr      = hostAddr;
				memWriteData = hostWriteData;
			end
			REQ_DATA: begin
				memWrite = dataWrite;
				memAddr  = dataAddr;
			end
			default: memWrite = 1'b0;
		endcase
	end

	assign memEnable = (grant != REQ_NONE);

	// Grant is none while owned, so ownership lasts one ack cycle
	always_ff @(posedge clk) begin
		if (reset)
			owner <= REQ_NONE;
		else
			owner <= grant;
	end

	assign hostAck      = (owner == REQ_HOST);
	assign dataAck      = (owner == REQ_DATA);
	assign fetchAck     = (owner == REQ_FETCH);
	assign hostReadData = hostAck ? memReadData : '0;
	assign ackData      = (dataAck || fetchAck) ? memReadData : '0;

	assert property (@(posedge clk) disable iff (reset)
		$onehot0({hostAck, dataAck, fetchAck}));

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module registerFile (
	input  logic             clk,
	input  logic             reset,
	input  logic             acWrite,
	input  cpuPkg::acSourceT acSource,
	input  logic             acInc,
	input  logic             acReset,
	input  logic             addrWrite,
	input  logic             addrInc,
	input  logic             pcWrite,
	input  logic             pcInc,
	input  cpuPkg::dataT     memWord,
	output cpuPkg::addrT     pc,
	output cpuPkg::addrT     addr,
	output cpuPkg::dataT     ac,
	output logic             acZero
);
	import cpuPkg::*;

	dataT sum;

	assign sum    = ac + dataT'(addr);  // ADD uses ADDR as operand
	assign acZero = (ac == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc   <= addrT'(`CPU_PC_RESET);
			addr <= '0;
			ac   <= '0;
		end else begin
			if (pcWrite)
				pc <= addrT'(memWord);
			else if (pcInc)
				pc <= pc + 1'b1;

			if (addrWrite)
				addr <= addrT'(memWord);
			else if (addrInc)
				addr <= addr + 1'b1;

			if (acReset)
				ac <= '0;
			else if (acInc)
				ac <= ac + 1'b1;
			else if (acWrite)
				ac <= (acSource == AC_FROM_SUM) ? sum : memWord;
		end
	end

	// Controller gives each register one action per cycle
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({acWrite, acInc, acReset}) && $onehot0({addrWrite, addrInc})
		&& $onehot0({pcWrite, pcInc}));

endmodule

//--- verilog/wordMemory.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module wordMemory (
	input  logic         clk,
	input  logic         enable,
	input  logic         write,
	input  cpuPkg::addrT address,
	input  cpuPkg::dataT writeData,
	output cpuPkg::dataT readData
);
	import cpuPkg::*;

	dataT mem [`CPU_MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (enable) begin
			if (write)
				mem[address] <= writeData;
			else
				readData <= mem[address];  // Holds its value across writes
		end
	end

endmodule
